// File: axil_noc_bridge.f
verilog/axil_noc_pkg.sv
verilog/sync_fifo.sv
verilog/write_req_queue.sv
verilog/read_req_queue.sv
verilog/request_order.sv
verilog/flit_serializer.sv
verilog/axil_noc_bridge.sv
verif/axil_noc_bridge_assert.sv
verif/axil_noc_bridge_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axil_noc_bridge_tb -f axil_noc_bridge.f \
    --Mdir obj_dir -o sim_axil_noc_bridge

./obj_dir/sim_axil_noc_bridge > sim.log
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

// File: verif/axil_noc_bridge_tests.txt
# op addr data strb, all hex except op
# op 1 = store, 2 = load, 3 = store and load in the same cycle
1 0000000000001000 1122334455667788 ff
2 0000000000002008 0000000000000000 00
1 0000ffff80000040 0123456789abcdef 0f
3 0000000000003000 a5a5a5a55a5a5a5a f0
2 ffff00000000abc8 0000000000000000 00
1 0000123456789ab0 fedcba9876543210 81
1 00000000deadbee8 0f0f0f0f0f0f0f0f 3c
2 0000000000000010 0000000000000000 00
3 0000aaaabbbbccc0 cafef00d12345678 01
2 0000000000004000 0000000000000000 00
1 7fff000000005558 8000000000000001 80
3 0000000000006660 0102030405060708 ff

// File: verif/axil_noc_bridge_tb.sv
//====================
// axil_noc_bridge_tb
// drives AXI-Lite requests from the tests file and
// checks every NoC flit against the expected stream
//====================
`timescale 1ns/1ps

module axil_noc_bridge_tb;

    localparam int          MAX_TESTS   = 64;
    localparam logic [13:0] DEST_CHIPID = 14'h0a5;
    localparam logic [7:0]  DEST_X      = 8'h03;
    localparam logic [7:0]  DEST_Y      = 8'h05;
    localparam logic [3:0]  DEST_F      = 4'hc;
    localparam logic [13:0] SRC_CHIPID  = 14'h1c2;
    localparam logic [7:0]  SRC_X       = 8'h06;
    localparam logic [7:0]  SRC_Y       = 8'h01;
    localparam logic [3:0]  SRC_F       = 4'h2;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [63:0] awaddr = '0;
    logic        awvalid = 1'b0;
    logic        awready;
    logic [63:0] wdata = '0;
    logic [7:0]  wstrb = '0;
    logic        wvalid = 1'b0;
    logic        wready;
    logic [63:0] araddr = '0;
    logic        arvalid = 1'b0;
    logic        arready;
    logic        noc_valid_out;
    logic [63:0] noc_data_out;
    logic        noc_ready_in = 1'b0;

    int          op_q[$];
    logic [63:0] addr_q[$];
    logic [63:0] data_q[$];
    logic [7:0]  strb_q[$];
    logic [63:0] exp_q[$];        // expected flits in acceptance order
    int          tag_q[$];        // test index of each expected flit
    int          flits_left[MAX_TESTS];
    int          test_err[MAX_TESTS];
    int          n_tests = 0;
    int          tests_done = 0;
    int          passed = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 200;
    logic [31:0] lcg_state = 32'd34037;

    axil_noc_bridge #(.DEPTH(8)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .dest_chipid   (DEST_CHIPID),
        .dest_xpos     (DEST_X),
        .dest_ypos     (DEST_Y),
        .dest_fbits    (DEST_F),
        .src_chipid    (SRC_CHIPID),
        .src_xpos      (SRC_X),
        .src_ypos      (SRC_Y),
        .src_fbits     (SRC_F),
        .noc_valid_out (noc_valid_out),
        .noc_data_out  (noc_data_out),
        .noc_ready_in  (noc_ready_in)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // AXI byte 0 ends up in the top byte of the flit
    function automatic logic [63:0] rev_bytes(input logic [63:0] d);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[63 - 8*i -: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    function automatic logic [7:0] rev_bits(input logic [7:0] s);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[7 - i] = s[i];
        end
        return r;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("MISMATCH %s exp=%h got=%h", name, exp, got);
            errors++;
        end
    endtask

    // header 0, header 1, header 2 and for a store the data flit
    task automatic push_expected(input int idx, input bit is_store);
        logic [63:0] addr;
        logic [7:0]  len;
        logic [7:0]  kind;
        logic [7:0]  mask;
        addr = addr_q[idx];
        len  = is_store ? 8'd3 : 8'd2;
        kind = is_store ? 8'd15 : 8'd14;
        mask = is_store ? rev_bits(strb_q[idx]) : 8'h00;
        exp_q.push_back({DEST_CHIPID, DEST_X, DEST_Y, DEST_F, len, kind, 14'h0});
        exp_q.push_back({addr[47:0], 3'b100, 5'h0, mask});
        exp_q.push_back({SRC_CHIPID, SRC_X, SRC_Y, SRC_F, 30'h0});
        repeat (3) tag_q.push_back(idx);
        if (is_store) begin
            exp_q.push_back(rev_bytes(data_q[idx]));
            tag_q.push_back(idx);
        end
    endtask

    task automatic run_test(input int idx);
        int op;
        bit aw_pend;
        bit w_pend;
        bit ar_pend;
        bit aw_fire;
        bit w_fire;
        bit ar_fire;
        op      = op_q[idx];
        aw_pend = (op == 1) || (op == 3);
        w_pend  = aw_pend;
        ar_pend = (op == 2) || (op == 3);
        @(posedge clk);
        awaddr  <= addr_q[idx];
        wdata   <= data_q[idx];
        wstrb   <= strb_q[idx];
        araddr  <= addr_q[idx];
        awvalid <= aw_pend;
        wvalid  <= w_pend;
        arvalid <= ar_pend;
        while (aw_pend || w_pend || ar_pend) begin
            @(negedge clk);
            aw_fire = awvalid && awready;  // transfer happens on the next rising edge
            w_fire  = wvalid && wready;
            ar_fire = arvalid && arready;
            if (aw_fire) push_expected(idx, 1'b1);  // store ordered first on a tie
            if (ar_fire) push_expected(idx, 1'b0);
            @(posedge clk);
            if (aw_fire) begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_fire) begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
            if (ar_fire) begin
                arvalid <= 1'b0;
                ar_pend = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        noc_ready_in <= (lcg_state[30:28] > 3'd2);  // ready about 5 cycles in 8
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d tests finished",
                     cycles, tests_done, n_tests);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : flit_monitor
        logic [63:0] exp_flit;
        int          t;
        if (rst_n && noc_valid_out && noc_ready_in) begin
            if (exp_q.size() == 0) begin
                $display("unexpected flit %h with no request pending", noc_data_out);
                errors++;
            end else begin
                exp_flit = exp_q.pop_front();
                t = tag_q.pop_front();
                if (noc_data_out !== exp_flit) begin
                    $display("MISMATCH noc_data_out exp=%h got=%h (test %0d)",
                             exp_flit, noc_data_out, t);
                    errors++;
                    test_err[t]++;
                end
                flits_left[t]--;
                if (flits_left[t] == 0) begin
                    $display("test %0d op %0d: %s", t, op_q[t],
                             (test_err[t] == 0) ? "ok" : "wrong flits");
                    if (test_err[t] == 0) passed++;
                    tests_done++;
                end
            end
        end
    end

    initial begin
        int          fd;
        string       line;
        int          op;
        logic [63:0] a;
        logic [63:0] d;
        logic [7:0]  s;
        fd = $fopen("verif/axil_noc_bridge_tests.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#" && n_tests < MAX_TESTS &&
                    $sscanf(line, "%d %h %h %h", op, a, d, s) == 4) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    strb_q.push_back(s);
                    flits_left[n_tests] = (op == 1) ? 4 : (op == 2) ? 3 : 7;
                    test_err[n_tests] = 0;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * n_tests + 200;
        if (n_tests == 0) begin
            $display("no tests read from verif/axil_noc_bridge_tests.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            check_bit("noc_valid_out", 1'b0, noc_valid_out);
            check_bit("awready", 1'b1, awready);
            check_bit("wready", 1'b1, wready);
            check_bit("arready", 1'b1, arready);
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            while (tests_done < n_tests) @(negedge clk);
            repeat (20) @(negedge clk);  // catch stray flits
            $display("tests %0d passed %0d failed %0d errors %0d",
                     n_tests, passed, n_tests - passed, errors);
            if (errors == 0 && passed == n_tests) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// File: verif/axil_noc_bridge_assert.sv
//====================
// axil_noc_bridge_assert
// protocol checks on the NoC output port
//====================
`timescale 1ns/1ps

module axil_noc_bridge_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        noc_valid_out,
    input logic [63:0] noc_data_out,
    input logic        noc_ready_in
);

    // a flit that is offered stays offered, unchanged, until taken
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        noc_valid_out && !noc_ready_in |=> noc_valid_out)
        else $error("noc_valid_out dropped before the flit was accepted");

    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        noc_valid_out && !noc_ready_in |=> $stable(noc_data_out))
        else $error("noc_data_out changed while the flit was waiting");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !noc_valid_out)
        else $error("noc_valid_out high in the first cycle after reset");

endmodule

bind axil_noc_bridge axil_noc_bridge_assert i_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .noc_valid_out (noc_valid_out),
    .noc_data_out  (noc_data_out),
    .noc_ready_in  (noc_ready_in)
);

// File: verilog/axil_noc_bridge.sv
//====================
// axil_noc_bridge
// AXI-Lite request path into NoC flits: write and read
// queues, arrival order and the flit serializer
//====================
`timescale 1ns/1ps

module axil_noc_bridge #(
    parameter int DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [axil_noc_pkg::DATA_WIDTH-1:0]   wdata,
    input  logic [axil_noc_pkg::STRB_WIDTH-1:0]   wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [axil_noc_pkg::CHIPID_WIDTH-1:0] dest_chipid,
    input  logic [axil_noc_pkg::XPOS_WIDTH-1:0]   dest_xpos,
    input  logic [axil_noc_pkg::YPOS_WIDTH-1:0]   dest_ypos,
    input  logic [axil_noc_pkg::FBITS_WIDTH-1:0]  dest_fbits,
    input  logic [axil_noc_pkg::CHIPID_WIDTH-1:0] src_chipid,
    input  logic [axil_noc_pkg::XPOS_WIDTH-1:0]   src_xpos,
    input  logic [axil_noc_pkg::YPOS_WIDTH-1:0]   src_ypos,
    input  logic [axil_noc_pkg::FBITS_WIDTH-1:0]  src_fbits,
    output logic                                  noc_valid_out,
    output logic [axil_noc_pkg::DATA_WIDTH-1:0]   noc_data_out,
    input  logic                                  noc_ready_in
);

    import axil_noc_pkg::*;

    logic                  order_room;
    logic                  aw_accept;
    logic                  ar_accept;
    logic                  head_valid;
    req_kind_e             head_kind;
    logic                  store_ready;
    logic [ADDR_WIDTH-1:0] store_addr;
    logic [DATA_WIDTH-1:0] store_data;
    logic [STRB_WIDTH-1:0] store_strb;
    logic                  load_ready;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic                  order_pop;
    logic                  store_pop;
    logic                  load_pop;

    // port names match the local nets, only the order pop is renamed
    write_req_queue #(.DEPTH(DEPTH)) i_write_q (.*);

    read_req_queue #(.DEPTH(DEPTH)) i_read_q (.*);

    request_order #(.DEPTH(DEPTH)) i_order (
        .pop (order_pop),
        .*
    );

    flit_serializer i_serializer (.*);

endmodule

// File: verilog/flit_serializer.sv
//====================
// flit_serializer
// turns the head request into three header flits, plus a
// data flit for a store, and pops the queues on the last one
//====================
`timescale 1ns/1ps

module flit_serializer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  head_valid,
    input  axil_noc_pkg::req_kind_e               head_kind,
    input  logic                                  store_ready,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0]   store_addr,
    input  logic [axil_noc_pkg::DATA_WIDTH-1:0]   store_data,
    input  logic [axil_noc_pkg::STRB_WIDTH-1:0]   store_strb,
    input  logic                                  load_ready,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0]   load_addr,
    input  logic [axil_noc_pkg::CHIPID_WIDTH-1:0] dest_chipid,
    input  logic [axil_noc_pkg::XPOS_WIDTH-1:0]   dest_xpos,
    input  logic [axil_noc_pkg::YPOS_WIDTH-1:0]   dest_ypos,
    input  logic [axil_noc_pkg::FBITS_WIDTH-1:0]  dest_fbits,
    input  logic [axil_noc_pkg::CHIPID_WIDTH-1:0] src_chipid,
    input  logic [axil_noc_pkg::XPOS_WIDTH-1:0]   src_xpos,
    input  logic [axil_noc_pkg::YPOS_WIDTH-1:0]   src_ypos,
    input  logic [axil_noc_pkg::FBITS_WIDTH-1:0]  src_fbits,
    output logic                                  order_pop,
    output logic                                  store_pop,
    output logic                                  load_pop,
    output logic                                  noc_valid_out,
    output logic [axil_noc_pkg::DATA_WIDTH-1:0]   noc_data_out,
    input  logic                                  noc_ready_in
);

    import axil_noc_pkg::*;

    flit_state_e           state;
    flit_state_e           state_next;
    logic [1:0]            flit_cnt;  // header index
    logic                  is_store;
    logic                  is_load;
    logic                  req_ready;
    logic                  fire;
    logic                  last_hdr;
    logic                  last_flit;
    logic [ADDR_WIDTH-1:0] req_addr;

    assign is_store  = (head_kind == REQ_STORE);
    assign is_load   = (head_kind == REQ_LOAD);
    assign req_ready = head_valid && ((is_store && store_ready) || (is_load && load_ready));
    assign req_addr  = is_store ? store_addr : load_addr;

    assign noc_valid_out = (state == ST_HEADER) || (state == ST_DATA);
    assign fire          = noc_valid_out && noc_ready_in;
    assign last_hdr      = (state == ST_HEADER) && (flit_cnt == 2'(HDR_FLITS - 1));
    assign last_flit     = fire && ((last_hdr && is_load) || (state == ST_DATA));

    // head stays put until these pops, so the flit fields hold under back-pressure
    assign order_pop = last_flit;
    assign store_pop = last_flit && is_store;
    assign load_pop  = last_flit && is_load;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:   if (req_ready) state_next = ST_HEADER;
            ST_HEADER: if (fire && last_hdr) state_next = is_store ? ST_DATA : ST_IDLE;
            ST_DATA:   if (fire) state_next = ST_IDLE;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            flit_cnt <= '0;
        end else begin
            state <= state_next;
            if (fire && state == ST_HEADER) begin
                flit_cnt <= last_hdr ? 2'd0 : flit_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        noc_data_out = '0;  // unused bits stay zero
        if (state == ST_HEADER) begin
            case (flit_cnt)
                2'd0: begin
                    noc_data_out[CHIPID_HI:CHIPID_LO]     = dest_chipid;
                    noc_data_out[XPOS_HI:XPOS_LO]         = dest_xpos;
                    noc_data_out[YPOS_HI:YPOS_LO]         = dest_ypos;
                    noc_data_out[FBITS_HI:FBITS_LO]       = dest_fbits;
                    noc_data_out[MSG_LEN_HI:MSG_LEN_LO]   = is_store ? MSG_LEN_STORE : MSG_LEN_LOAD;
                    noc_data_out[MSG_TYPE_HI:MSG_TYPE_LO] = is_store ? NC_STORE_REQ : NC_LOAD_REQ;
                    noc_data_out[MSG_ID_HI:MSG_ID_LO]     = '0;  // one request in flight
                end
                2'd1: begin
                    noc_data_out[ADDR_HI:ADDR_LO]           = req_addr[PHY_ADDR_WIDTH-1:0];
                    noc_data_out[DATA_SIZE_HI:DATA_SIZE_LO] = DATA_SIZE_8B;
                    // one strobe bit per byte, so byte order reversal is a bit reversal
                    noc_data_out[MASK_HI:MASK_LO] = is_store ? {<<{store_strb}} : '0;
                end
                2'd2: begin
                    noc_data_out[CHIPID_HI:CHIPID_LO] = src_chipid;
                    noc_data_out[XPOS_HI:XPOS_LO]     = src_xpos;
                    noc_data_out[YPOS_HI:YPOS_LO]     = src_ypos;
                    noc_data_out[FBITS_HI:FBITS_LO]   = src_fbits;
                end
                default: noc_data_out = '0;
            endcase
        end else if (state == ST_DATA) begin
            noc_data_out = {<<8{store_data}};  // AXI byte 0 lands in the top byte
        end
    end

endmodule

// File: verilog/request_order.sv
//====================
// request_order
// keeps the arrival order of stores and loads; a store and
// a load accepted together go in as store, then load
//====================
`timescale 1ns/1ps

module request_order #(
    parameter int DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    aw_accept,
    input  logic                    ar_accept,
    output logic                    order_room,
    output logic                    head_valid,
    output axil_noc_pkg::req_kind_e head_kind,
    input  logic                    pop
);

    import axil_noc_pkg::*;

    logic                          held_load;  // load waiting behind a same-cycle store
    logic                          order_full;
    logic                          order_empty;
    logic                          push;
    req_kind_e                     push_kind;
    logic [$bits(req_kind_e)-1:0]  head_raw;

    assign order_room = !order_full && !held_load;
    assign head_valid = !order_empty;
    assign head_kind  = req_kind_e'(head_raw);
    assign push       = held_load || aw_accept || ar_accept;

    always_comb begin
        if (held_load) begin
            push_kind = REQ_LOAD;
        end else if (aw_accept) begin
            push_kind = REQ_STORE;  // store wins a tie
        end else if (ar_accept) begin
            push_kind = REQ_LOAD;
        end else begin
            push_kind = REQ_NONE;
        end
    end

    // if the store took the last slot the load stays held until a pop frees one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_load <= 1'b0;
        end else if (held_load) begin
            held_load <= order_full;
        end else begin
            held_load <= aw_accept && ar_accept;
        end
    end

    sync_fifo #(.DSIZE($bits(req_kind_e)), .DEPTH(DEPTH)) i_kind_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wval  (push),
        .wdata (push_kind),
        .full  (order_full),
        .ren   (pop),
        .rdata (head_raw),
        .empty (order_empty)
    );

endmodule

// File: verilog/read_req_queue.sv
//====================
// read_req_queue
// queues AR beats in order, presents the oldest load
//====================
`timescale 1ns/1ps

module read_req_queue #(
    parameter int DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic                                order_room,
    output logic                                ar_accept,
    output logic                                load_ready,
    output logic [axil_noc_pkg::ADDR_WIDTH-1:0] load_addr,
    input  logic                                load_pop
);

    import axil_noc_pkg::*;

    logic ar_full;
    logic ar_empty;

    assign arready    = !ar_full && order_room;
    assign ar_accept  = arvalid && arready;
    assign load_ready = !ar_empty;

    sync_fifo #(.DSIZE(ADDR_WIDTH), .DEPTH(DEPTH)) i_addr_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wval  (ar_accept),
        .wdata (araddr),
        .full  (ar_full),
        .ren   (load_pop),
        .rdata (load_addr),
        .empty (ar_empty)
    );

endmodule

// File: verilog/write_req_queue.sv
//====================
// write_req_queue
// queues AW and W beats, presents the oldest complete store
//====================
`timescale 1ns/1ps

module write_req_queue #(
    parameter int DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [axil_noc_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axil_noc_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [axil_noc_pkg::STRB_WIDTH-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic                                order_room,
    output logic                                aw_accept,
    output logic                                store_ready,
    output logic [axil_noc_pkg::ADDR_WIDTH-1:0] store_addr,
    output logic [axil_noc_pkg::DATA_WIDTH-1:0] store_data,
    output logic [axil_noc_pkg::STRB_WIDTH-1:0] store_strb,
    input  logic                                store_pop
);

    import axil_noc_pkg::*;

    localparam int WD_W = STRB_WIDTH + DATA_WIDTH;  // strobe and data share one entry

    logic            aw_full;
    logic            aw_empty;
    logic            wd_full;
    logic            wd_empty;
    logic            w_accept;
    logic [WD_W-1:0] wd_head;

    // address also needs a slot in the order queue, data does not
    assign awready   = !aw_full && order_room;
    assign wready    = !wd_full;
    assign aw_accept = awvalid && awready;
    assign w_accept  = wvalid && wready;

    assign store_ready = !aw_empty && !wd_empty;  // W may arrive before or after AW
    assign store_data  = wd_head[DATA_WIDTH-1:0];
    assign store_strb  = wd_head[WD_W-1:DATA_WIDTH];

    sync_fifo #(.DSIZE(ADDR_WIDTH), .DEPTH(DEPTH)) i_addr_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wval  (aw_accept),
        .wdata (awaddr),
        .full  (aw_full),
        .ren   (store_pop),
        .rdata (store_addr),
        .empty (aw_empty)
    );

    sync_fifo #(.DSIZE(WD_W), .DEPTH(DEPTH)) i_data_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wval  (w_accept),
        .wdata ({wstrb, wdata}),
        .full  (wd_full),
        .ren   (store_pop),
        .rdata (wd_head),
        .empty (wd_empty)
    );

endmodule

// File: verilog/sync_fifo.sv
//====================
// sync_fifo
// single-clock circular buffer, rdata shows the oldest entry
//====================
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DSIZE = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wval,
    input  logic [DSIZE-1:0] wdata,
    output logic             full,
    input  logic             ren,
    output logic [DSIZE-1:0] rdata,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DSIZE-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // occupancy
    logic             do_write;
    logic             do_read;

    // wrap explicitly so a depth that is not a power of two still works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_write = wval && !full;
    assign do_read  = ren && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign rdata    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

endmodule

// File: verilog/axil_noc_pkg.sv
//====================
// axil_noc_pkg
// widths, flit field positions, message codes and
// enums shared by the AXI-Lite to NoC request bridge
//====================
package axil_noc_pkg;

    // AXI-Lite side
    localparam int ADDR_WIDTH     = 64;
    localparam int DATA_WIDTH     = 64;  // also the flit width
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;
    localparam int PHY_ADDR_WIDTH = 48;  // address bits carried in header 1

    // node id fields, same positions in header 0 (dest) and header 2 (src)
    localparam int CHIPID_HI = 63;
    localparam int CHIPID_LO = 50;
    localparam int XPOS_HI   = 49;
    localparam int XPOS_LO   = 42;
    localparam int YPOS_HI   = 41;
    localparam int YPOS_LO   = 34;
    localparam int FBITS_HI  = 33;
    localparam int FBITS_LO  = 30;

    localparam int CHIPID_WIDTH = CHIPID_HI - CHIPID_LO + 1;
    localparam int XPOS_WIDTH   = XPOS_HI - XPOS_LO + 1;
    localparam int YPOS_WIDTH   = YPOS_HI - YPOS_LO + 1;
    localparam int FBITS_WIDTH  = FBITS_HI - FBITS_LO + 1;

    // rest of header 0
    localparam int MSG_LEN_HI  = 29;
    localparam int MSG_LEN_LO  = 22;
    localparam int MSG_TYPE_HI = 21;
    localparam int MSG_TYPE_LO = 14;
    localparam int MSG_ID_HI   = 13;
    localparam int MSG_ID_LO   = 6;

    // header 1
    localparam int ADDR_HI      = 63;
    localparam int ADDR_LO      = 16;
    localparam int DATA_SIZE_HI = 15;
    localparam int DATA_SIZE_LO = 13;
    localparam int MASK_HI      = 7;
    localparam int MASK_LO      = 0;

    localparam logic [7:0] MSG_LEN_STORE = 8'd3;  // two more headers plus one data flit
    localparam logic [7:0] MSG_LEN_LOAD  = 8'd2;
    localparam logic [2:0] DATA_SIZE_8B  = 3'b100;
    localparam int         HDR_FLITS     = 3;

    typedef enum logic [7:0] {
        NC_LOAD_REQ  = 8'd14,
        NC_STORE_REQ = 8'd15
    } noc_msg_e;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_LOAD,
        REQ_STORE
    } req_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA
    } flit_state_e;

endpackage
